// File: rtl/master_translator_cfg.svh
// fixed configuration of the Avalon master translator
// widths and symbol counts shared by the package and the RTL
// include wherever a width or a symbol count is needed

`ifndef MASTER_TRANSLATOR_CFG_SVH
`define MASTER_TRANSLATOR_CFG_SVH

// master side, word addressed
`define MT_AV_ADDRESS_W      16
`define MT_AV_DATA_W         32
`define MT_AV_BYTEENABLE_W   4
`define MT_AV_BURSTCOUNT_W   4

// symbols (bytes) per word and the byte offset bits they need
`define MT_SYMBOLS_PER_WORD  4
`define MT_BITS_PER_WORD     2

// universal side, byte addressed
`define MT_UAV_ADDRESS_W     18
`define MT_UAV_BURSTCOUNT_W  6

`endif

// File: rtl/translator_pkg.sv
// types of the Avalon master translator
// master and universal address, burstcount and data types
// refer to them as translator_pkg::name
`default_nettype none

`include "master_translator_cfg.svh"

package translator_pkg;

   typedef logic [`MT_AV_ADDRESS_W-1:0]     av_addr_t;
   typedef logic [`MT_AV_BURSTCOUNT_W-1:0]  av_burst_t;
   typedef logic [`MT_AV_DATA_W-1:0]        data_t;
   typedef logic [`MT_AV_BYTEENABLE_W-1:0]  byteen_t;
   typedef logic [`MT_UAV_BURSTCOUNT_W-1:0] uav_burst_t;

   // remaining beats of a burst, counted in words
   typedef logic [`MT_UAV_BURSTCOUNT_W-`MT_BITS_PER_WORD-1:0] burstlen_t;

   // byte address split into the word it falls in and the byte within it
   typedef struct packed {
      logic [`MT_AV_ADDRESS_W-1:0]  word_index;
      logic [`MT_BITS_PER_WORD-1:0] byte_offset;
   } word_addr_t;

   typedef union packed {
      logic [`MT_UAV_ADDRESS_W-1:0] byte_addr;
      word_addr_t                   word;
   } uav_addr_u;

endpackage

`default_nettype wire

// File: rtl/burst_tracker.sv
// transfer and burst start tracking for the master translator
// begin_transfer marks the first cycle of every beat
// begin_burst marks the first beat of a write burst, or any read
`timescale 1ns/1ps
`default_nettype none

module burst_tracker (
   input  logic clk,
   input  logic reset,
   input  logic uav_read,
   input  logic uav_write,
   input  logic uav_waitrequest,
   input  logic last_beat,
   output logic begin_transfer,
   output logic begin_burst
);

   // set while the current beat is stalled after its first cycle
   logic end_transfer;
   // set between the first and the last beat of a write burst
   logic in_write_burst;

   // ----------------------------------------------------------------------
   // transfer start
   // ----------------------------------------------------------------------

   assign begin_transfer = (uav_write | uav_read) & ~end_transfer;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         end_transfer <= 1'b0;
      end else if (uav_waitrequest) begin
         // a stalled beat keeps the flag until it is taken
         if (begin_transfer) begin
            end_transfer <= 1'b1;
         end
      end else begin
         end_transfer <= 1'b0;
      end
   end

   // ----------------------------------------------------------------------
   // burst start
   // ----------------------------------------------------------------------

   // every read command is a burst of its own
   assign begin_burst = uav_read ? begin_transfer : (begin_transfer & ~in_write_burst);

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         in_write_burst <= 1'b0;
      end else if (uav_read || (begin_transfer && last_beat)) begin
         // the last beat has started, the next write opens a new burst
         in_write_burst <= 1'b0;
      end else if (uav_write && begin_transfer) begin
         in_write_burst <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: rtl/beat_address_gen.sv
// per-beat address and burstcount generation for the master translator
// converts word units to byte units and, inside a write burst, gives
// every beat its own byte address and remaining byte burstcount
`timescale 1ns/1ps
`default_nettype none

`include "master_translator_cfg.svh"

module beat_address_gen (
   input  logic                   clk,
   input  logic                   reset,
   input  translator_pkg::av_addr_t   av_address,
   input  translator_pkg::av_burst_t  av_burstcount,
   input  logic                   uav_write,
   input  logic                   uav_waitrequest,
   input  logic                   begin_transfer,
   input  logic                   begin_burst,
   output translator_pkg::uav_addr_u  uav_address,
   output translator_pkg::uav_burst_t uav_burstcount,
   output logic                   last_beat
);

   // byte step between two consecutive beats
   localparam logic [`MT_UAV_ADDRESS_W-1:0] WORD_STEP =
      `MT_UAV_ADDRESS_W'(`MT_SYMBOLS_PER_WORD);

   translator_pkg::uav_addr_u addr_pre;
   translator_pkg::uav_addr_u addr_reg;
   translator_pkg::burstlen_t len_pre;
   translator_pkg::burstlen_t len_reg;
   translator_pkg::burstlen_t len_cur;

   // ----------------------------------------------------------------------
   // unit conversion
   // ----------------------------------------------------------------------

   // word address lands on the first byte of its word
   always_comb begin
      addr_pre.word.word_index  = av_address;
      addr_pre.word.byte_offset = '0;
   end

   assign len_pre = av_burstcount;

   // ----------------------------------------------------------------------
   // beat selection
   // ----------------------------------------------------------------------

   // first beat of a burst shows the master's values directly
   assign uav_address = begin_burst ? addr_pre : addr_reg;
   assign len_cur     = begin_burst ? len_pre : len_reg;

   // remaining words shown as bytes
   assign uav_burstcount = {len_cur, {`MT_BITS_PER_WORD{1'b0}}};

   assign last_beat = (len_cur == translator_pkg::burstlen_t'(1));

   // ----------------------------------------------------------------------
   // running address and remaining length
   // ----------------------------------------------------------------------

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         addr_reg <= '0;
         len_reg  <= '0;
      end else if (begin_transfer && uav_waitrequest) begin
         // capture the stalled beat so it holds once begin_burst drops
         addr_reg <= uav_address;
         len_reg  <= len_cur;
      end else if (uav_write && !uav_waitrequest) begin
         // write beat taken, step to the next word
         addr_reg.byte_addr <= uav_address.byte_addr + WORD_STEP;
         len_reg            <= len_cur - translator_pkg::burstlen_t'(1);
      end
   end

endmodule

`default_nettype wire

// File: rtl/master_translator.sv
// Avalon-MM master translator, top level
// word-addressed bursting master in, byte-addressed universal master out
// data, byteenable and the handshakes pass straight through
`timescale 1ns/1ps
`default_nettype none

module master_translator (
   input  logic                       clk,
   input  logic                       reset,

   // master side
   input  logic                       av_read,
   input  logic                       av_write,
   input  translator_pkg::av_addr_t   av_address,
   input  translator_pkg::av_burst_t  av_burstcount,
   input  translator_pkg::byteen_t    av_byteenable,
   input  translator_pkg::data_t      av_writedata,
   output logic                       av_waitrequest,
   output translator_pkg::data_t      av_readdata,
   output logic                       av_readdatavalid,

   // universal side
   output logic                       uav_read,
   output logic                       uav_write,
   output translator_pkg::uav_addr_u  uav_address,
   output translator_pkg::uav_burst_t uav_burstcount,
   output translator_pkg::byteen_t    uav_byteenable,
   output translator_pkg::data_t      uav_writedata,
   input  logic                       uav_waitrequest,
   input  translator_pkg::data_t      uav_readdata,
   input  logic                       uav_readdatavalid
);

   logic begin_transfer;
   logic begin_burst;
   logic last_beat;

   // ----------------------------------------------------------------------
   // pass-through paths
   // ----------------------------------------------------------------------

   assign uav_read         = av_read;
   assign uav_write        = av_write;
   assign uav_writedata    = av_writedata;
   assign uav_byteenable   = av_byteenable;
   assign av_readdata      = uav_readdata;
   assign av_readdatavalid = uav_readdatavalid;
   assign av_waitrequest   = uav_waitrequest;

   // ----------------------------------------------------------------------
   // burst tracking and per-beat address
   // ----------------------------------------------------------------------

   burst_tracker u_burst_tracker (
      .clk             (clk),
      .reset           (reset),
      .uav_read        (uav_read),
      .uav_write       (uav_write),
      .uav_waitrequest (uav_waitrequest),
      .last_beat       (last_beat),
      .begin_transfer  (begin_transfer),
      .begin_burst     (begin_burst)
   );

   beat_address_gen u_beat_address_gen (
      .clk             (clk),
      .reset           (reset),
      .av_address      (av_address),
      .av_burstcount   (av_burstcount),
      .uav_write       (uav_write),
      .uav_waitrequest (uav_waitrequest),
      .begin_transfer  (begin_transfer),
      .begin_burst     (begin_burst),
      .uav_address     (uav_address),
      .uav_burstcount  (uav_burstcount),
      .last_beat       (last_beat)
   );

endmodule

`default_nettype wire

// File: verification/translator_assertions.sv
// concurrent checks on the Avalon master rules and translator invariants
// bound to the translator top level by the testbench
`timescale 1ns/1ps
`default_nettype none

module translator_assertions (
   input logic                       clk,
   input logic                       reset,
   input logic                       av_read,
   input logic                       av_write,
   input translator_pkg::av_addr_t   av_address,
   input translator_pkg::av_burst_t  av_burstcount,
   input translator_pkg::byteen_t    av_byteenable,
   input translator_pkg::data_t      av_writedata,
   input logic                       av_waitrequest,
   input logic                       uav_read,
   input logic                       uav_write,
   input translator_pkg::uav_addr_u  uav_address,
   input translator_pkg::uav_burst_t uav_burstcount,
   input logic                       uav_waitrequest
);

   int unsigned assert_errors = 0;

   // ----------------------------------------------------------------------
   // master side
   // ----------------------------------------------------------------------

   waitrequest_wire: assert property (@(posedge clk) disable iff (reset)
      av_waitrequest == uav_waitrequest)
      else begin
         assert_errors++;
         $error("av_waitrequest differs from uav_waitrequest");
      end

   read_held: assert property (@(posedge clk) disable iff (reset)
      av_read && av_waitrequest |=>
         av_read && $stable(av_address) && $stable(av_burstcount))
      else begin
         assert_errors++;
         $error("stalled read command changed");
      end

   write_held: assert property (@(posedge clk) disable iff (reset)
      av_write && av_waitrequest |=>
         av_write && $stable(av_address) && $stable(av_burstcount) &&
         $stable(av_writedata) && $stable(av_byteenable))
      else begin
         assert_errors++;
         $error("stalled write beat changed");
      end

   // ----------------------------------------------------------------------
   // universal side
   // ----------------------------------------------------------------------

   beat_held: assert property (@(posedge clk) disable iff (reset)
      (uav_read || uav_write) && uav_waitrequest |=>
         $stable(uav_address.byte_addr) && $stable(uav_burstcount))
      else begin
         assert_errors++;
         $error("stalled beat address or burstcount changed");
      end

   // every beat still owes at least one word
   beat_count: assert property (@(posedge clk) disable iff (reset)
      (uav_read || uav_write) |-> uav_burstcount != '0)
      else begin
         assert_errors++;
         $error("beat has no burstcount");
      end

endmodule

`default_nettype wire

// File: verification/translator_tb.sv
// self-checking testbench for the Avalon master translator
// a random master issues reads and write bursts against a random slave
// that stalls and returns read data
// every beat is compared with a word-to-byte model
`timescale 1ns/1ps
`default_nettype none

`include "master_translator_cfg.svh"

module translator_tb;

   localparam int NUM_TESTS  = 80;
   localparam int WAIT_LIMIT = 200;

   logic                       clk;
   logic                       reset;
   logic                       av_read;
   logic                       av_write;
   translator_pkg::av_addr_t   av_address;
   translator_pkg::av_burst_t  av_burstcount;
   translator_pkg::byteen_t    av_byteenable;
   translator_pkg::data_t      av_writedata;
   logic                       av_waitrequest;
   translator_pkg::data_t      av_readdata;
   logic                       av_readdatavalid;
   logic                       uav_read;
   logic                       uav_write;
   translator_pkg::uav_addr_u  uav_address;
   translator_pkg::uav_burst_t uav_burstcount;
   translator_pkg::byteen_t    uav_byteenable;
   translator_pkg::data_t      uav_writedata;
   logic                       uav_waitrequest;
   translator_pkg::data_t      uav_readdata;
   logic                       uav_readdatavalid;

   integer seed = 32'ha6d0_eacc;
   int     test_errors;
   int     tests_passed;
   int     tests_failed;
   bit     timed_out;
   // words the slave has returned in order
   translator_pkg::data_t read_words[$];

   master_translator uut (
      .clk               (clk),
      .reset             (reset),
      .av_read           (av_read),
      .av_write          (av_write),
      .av_address        (av_address),
      .av_burstcount     (av_burstcount),
      .av_byteenable     (av_byteenable),
      .av_writedata      (av_writedata),
      .av_waitrequest    (av_waitrequest),
      .av_readdata       (av_readdata),
      .av_readdatavalid  (av_readdatavalid),
      .uav_read          (uav_read),
      .uav_write         (uav_write),
      .uav_address       (uav_address),
      .uav_burstcount    (uav_burstcount),
      .uav_byteenable    (uav_byteenable),
      .uav_writedata     (uav_writedata),
      .uav_waitrequest   (uav_waitrequest),
      .uav_readdata      (uav_readdata),
      .uav_readdatavalid (uav_readdatavalid)
   );

   bind master_translator translator_assertions u_assertions (
      .clk             (clk),
      .reset           (reset),
      .av_read         (av_read),
      .av_write        (av_write),
      .av_address      (av_address),
      .av_burstcount   (av_burstcount),
      .av_byteenable   (av_byteenable),
      .av_writedata    (av_writedata),
      .av_waitrequest  (av_waitrequest),
      .uav_read        (uav_read),
      .uav_write       (uav_write),
      .uav_address     (uav_address),
      .uav_burstcount  (uav_burstcount),
      .uav_waitrequest (uav_waitrequest)
   );

   always #10 clk = ~clk;

   // ----------------------------------------------------------------------
   // model of the expected beats
   // ----------------------------------------------------------------------

   // beat k of a burst sits k words above the byte address of the start word
   function automatic translator_pkg::uav_addr_u beat_address(
      input translator_pkg::av_addr_t start, input int k);
      translator_pkg::uav_addr_u         a;
      logic [`MT_UAV_ADDRESS_W-1:0] base;
      base = `MT_UAV_ADDRESS_W'(start) * `MT_UAV_ADDRESS_W'(`MT_SYMBOLS_PER_WORD);
      a.byte_addr = base + `MT_UAV_ADDRESS_W'(k * `MT_SYMBOLS_PER_WORD);
      return a;
   endfunction

   // remaining words of the burst counted in bytes
   function automatic translator_pkg::uav_burst_t beat_burstcount(
      input translator_pkg::av_burst_t len, input int k);
      return translator_pkg::uav_burst_t'((int'(len) - k) * `MT_SYMBOLS_PER_WORD);
   endfunction

   // ----------------------------------------------------------------------
   // compare tasks
   // ----------------------------------------------------------------------

   task automatic check_addr(input string name, input translator_pkg::uav_addr_u got,
                             input translator_pkg::uav_addr_u exp);
      if (got.byte_addr !== exp.byte_addr) begin
         $display("FAILED %s got 0x%h expected 0x%h", name, got.byte_addr, exp.byte_addr);
         test_errors++;
      end
   endtask

   task automatic check_burst(input string name, input translator_pkg::uav_burst_t got,
                              input translator_pkg::uav_burst_t exp);
      if (got !== exp) begin
         $display("FAILED %s got 0x%h expected 0x%h", name, got, exp);
         test_errors++;
      end
   endtask

   task automatic check_data(input string name, input translator_pkg::data_t got,
                             input translator_pkg::data_t exp);
      if (got !== exp) begin
         $display("FAILED %s got 0x%h expected 0x%h", name, got, exp);
         test_errors++;
      end
   endtask

   task automatic check_byteen(input string name, input translator_pkg::byteen_t got,
                               input translator_pkg::byteen_t exp);
      if (got !== exp) begin
         $display("FAILED %s got 0x%h expected 0x%h", name, got, exp);
         test_errors++;
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("FAILED %s got 0x%h expected 0x%h", name, got, exp);
         test_errors++;
      end
   endtask

   // ----------------------------------------------------------------------
   // master side
   // ----------------------------------------------------------------------

   // holds each beat until it is taken and checks it on every cycle
   task automatic run_write(input translator_pkg::av_addr_t addr,
                            input translator_pkg::av_burst_t len);
      int                      cycles;
      bit                      accepted;
      translator_pkg::data_t   word;
      translator_pkg::byteen_t be;
      for (int k = 0; k < int'(len) && !timed_out; k++) begin
         word          = translator_pkg::data_t'($random(seed));
         be            = translator_pkg::byteen_t'($random(seed));
         av_write      = 1'b1;
         av_address    = addr;
         av_burstcount = len;
         av_byteenable = be;
         av_writedata  = word;
         accepted      = 1'b0;
         cycles        = 0;
         while (!accepted && !timed_out) begin
            @(negedge clk);
            check_flag("uav_write", uav_write, 1'b1);
            check_flag("uav_read", uav_read, 1'b0);
            check_addr("uav_address", uav_address, beat_address(addr, k));
            check_burst("uav_burstcount", uav_burstcount, beat_burstcount(len, k));
            check_byteen("uav_byteenable", uav_byteenable, be);
            check_data("uav_writedata", uav_writedata, word);
            accepted = !av_waitrequest;
            @(posedge clk);
            #1;
            cycles++;
            if (!accepted && cycles >= WAIT_LIMIT) begin
               $display("timeout: write beat %0d was never accepted", k);
               test_errors++;
               timed_out = 1'b1;
            end
         end
      end
      av_write = 1'b0;
   endtask

   task automatic run_read(input translator_pkg::av_addr_t addr,
                           input translator_pkg::av_burst_t len);
      int                    cycles;
      int                    got;
      bit                    accepted;
      translator_pkg::data_t exp_word;
      av_read       = 1'b1;
      av_address    = addr;
      av_burstcount = len;
      accepted      = 1'b0;
      cycles        = 0;
      while (!accepted && !timed_out) begin
         @(negedge clk);
         check_flag("uav_read", uav_read, 1'b1);
         check_flag("uav_write", uav_write, 1'b0);
         check_addr("uav_address", uav_address, beat_address(addr, 0));
         check_burst("uav_burstcount", uav_burstcount, beat_burstcount(len, 0));
         accepted = !av_waitrequest;
         @(posedge clk);
         #1;
         cycles++;
         if (!accepted && cycles >= WAIT_LIMIT) begin
            $display("timeout: read command was never accepted");
            test_errors++;
            timed_out = 1'b1;
         end
      end
      av_read = 1'b0;
      got     = 0;
      cycles  = 0;
      while (got < int'(len) && !timed_out) begin
         @(negedge clk);
         if (av_readdatavalid) begin
            if (read_words.size() == 0) begin
               $display("readdatavalid came back with no word sent by the slave");
               test_errors++;
            end else begin
               exp_word = read_words.pop_front();
               check_data("av_readdata", av_readdata, exp_word);
            end
            got++;
         end
         @(posedge clk);
         #1;
         cycles++;
         if (got < int'(len) && cycles >= WAIT_LIMIT) begin
            $display("timeout: only %0d of %0d read words came back", got, len);
            test_errors++;
            timed_out = 1'b1;
         end
      end
   endtask

   task automatic report_test(input int t, input int kind,
                              input translator_pkg::av_addr_t addr,
                              input translator_pkg::av_burst_t len);
      string what;
      case (kind)
         0:       what = "single read";
         1:       what = "single write";
         2:       what = "write burst";
         default: what = "read burst";
      endcase
      if (test_errors == 0) begin
         tests_passed++;
         $display("test %0d %s addr 0x%h len %0d ok", t, what, addr, len);
      end else begin
         tests_failed++;
         $display("test %0d %s addr 0x%h len %0d with %0d errors",
                  t, what, addr, len, test_errors);
      end
   endtask

   // ----------------------------------------------------------------------
   // slave side with random stalls and random read data latency
   // ----------------------------------------------------------------------

   initial begin : slave
      int                    pending;
      logic                  next_wait;
      logic                  next_valid;
      translator_pkg::data_t next_word;
      pending           = 0;
      uav_waitrequest   = 1'b0;
      uav_readdata      = '0;
      uav_readdatavalid = 1'b0;
      forever begin
         @(negedge clk);
         if (!reset && uav_read && !uav_waitrequest) begin
            pending = pending + int'(uav_burstcount) / `MT_SYMBOLS_PER_WORD;
         end
         next_wait  = (($random(seed) & 32'h7) < 32'd3);
         next_valid = (pending > 0) && (($random(seed) & 32'h1) != 32'd0);
         next_word  = translator_pkg::data_t'($random(seed));
         @(posedge clk);
         #1;
         uav_waitrequest   = next_wait;
         uav_readdatavalid = next_valid;
         uav_readdata      = next_word;
         if (next_valid) begin
            read_words.push_back(next_word);
            pending--;
         end
      end
   end

   // ----------------------------------------------------------------------
   // test sequence
   // ----------------------------------------------------------------------

   initial begin : main
      int                        kind;
      int                        gap;
      translator_pkg::av_addr_t  addr;
      translator_pkg::av_burst_t len;
      clk           = 1'b0;
      reset         = 1'b1;
      av_read       = 1'b0;
      av_write      = 1'b0;
      av_address    = '0;
      av_burstcount = '0;
      av_byteenable = '0;
      av_writedata  = '0;
      tests_passed  = 0;
      tests_failed  = 0;
      timed_out     = 1'b0;
      repeat (4) @(posedge clk);
      #1;
      reset = 1'b0;
      for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
         kind = $random(seed) & 32'h3;
         addr = translator_pkg::av_addr_t'($random(seed));
         len  = translator_pkg::av_burst_t'(($random(seed) & 32'h7) + 32'd1);
         if (kind < 2) begin
            len = translator_pkg::av_burst_t'(1);
         end
         test_errors = 0;
         if (kind == 0 || kind == 3) begin
            run_read(addr, len);
         end else begin
            run_write(addr, len);
         end
         report_test(t, kind, addr, len);
         // half of the commands follow back to back with no idle cycle
         gap = $random(seed) & 32'h3;
         repeat (gap / 2) begin
            @(posedge clk);
            #1;
         end
      end
      $display("tests run %0d, passed %0d, failed %0d, assertion errors %0d",
               tests_passed + tests_failed, tests_passed, tests_failed,
               uut.u_assertions.assert_errors);
      if (tests_failed == 0 && !timed_out && uut.u_assertions.assert_errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: all.f
+incdir+rtl
rtl/translator_pkg.sv
rtl/burst_tracker.sv
rtl/beat_address_gen.sv
rtl/master_translator.sv
verification/translator_assertions.sv
verification/translator_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the translator testbench with Verilator.
set -e

verilator --binary --timing --assert -f all.f --top-module translator_tb \
   -Mdir obj_dir -o Vtranslator_tb

status=0
./obj_dir/Vtranslator_tb +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Test failed" sim.log || ! grep -q "Test passed" sim.log; then
   echo "simulation reported failure"
   exit 1
fi
echo "simulation finished without failure"
